/* Makefile */
# Verilator build and run of the SPI command front end testbench

SRCS := $(wildcard hw/*.sv verif/*.sv include/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_spi_cmd

obj_dir/Vtb_spi_cmd: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_spi_cmd \
		-Mdir obj_dir -o Vtb_spi_cmd

run: obj_dir/Vtb_spi_cmd
	./obj_dir/Vtb_spi_cmd

clean:
	rm -rf obj_dir

/* all.f */
+incdir+include
hw/spi_cmd_pkg.sv
hw/spi_mosi_crc.sv
hw/spi_cmd_decoder.sv
hw/cmd_queue.sv
hw/cmd_dispatcher.sv
hw/spi_cmd_top.sv
verif/tb_spi_cmd.sv

/* hw/cmd_dispatcher.sv */
// ################################################
// drains committed queue words one per cycle and
// rebuilds them into whole command packets
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module cmd_dispatcher (
	input  logic                      clk_rst,
	input  logic                      i_rst_n,
	input  spi_cmd_pkg::spi_word_t    i_head,
	input  logic                      i_empty,
	output logic                      o_pop,
	output spi_cmd_pkg::cmd_packet_t  o_cmd,
	output logic                      o_cmd_valid
);

	localparam int ARG_IW = $clog2(`SPI_CMD_MAX_ARGS);

	spi_cmd_pkg::cmd_len_t remain, head_len; // remain is 0 between commands
	logic [ARG_IW-1:0]     arg_idx;

	assign o_pop    = !i_empty;
	assign head_len = spi_cmd_pkg::spi_cmd_length(i_head.opcode);

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			remain      <= '0;
			arg_idx     <= '0;
			o_cmd_valid <= 1'b0;
		end
		else begin
			o_cmd_valid <= 1'b0;
			if (o_pop) begin
				if (remain == '0) begin
					arg_idx <= '0;
					if (head_len > 2'd1)
						remain <= head_len - 2'd1;
					else
						o_cmd_valid <= 1'b1; // single word command
				end
				else begin
					remain  <= remain - 2'd1;
					arg_idx <= arg_idx + 1'b1;
					if (remain == 2'd1)
						o_cmd_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		if (o_pop) begin
			if (remain == '0) begin
				o_cmd.opcode <= i_head.opcode;
				o_cmd.data   <= i_head.data;
				o_cmd.args   <= '0; // zero fill for short commands
			end
			else begin
				o_cmd.args[arg_idx] <= i_head;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cmd_queue.sv */
// ################################################
// command FIFO with staged writes; words become
// visible to the reader only after a commit
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module cmd_queue #(
	parameter int DEPTH = `SPI_QUEUE_DEPTH // power of two
) (
	input  logic                         clk_rst,
	input  logic                         i_rst_n,
	input  spi_cmd_pkg::queue_op_t       i_op,
	input  logic                         i_clear,
	input  logic                         i_pop,
	output spi_cmd_pkg::spi_word_t       o_head,
	output logic                         o_empty,
	output logic [$clog2(DEPTH+1)-1:0]   o_free
);

	localparam int AW = $clog2(DEPTH);
	localparam int FW = $clog2(DEPTH + 1);

	spi_cmd_pkg::spi_word_t mem [DEPTH];

	logic [AW:0] wr_ptr, cmt_ptr, rd_ptr; // one extra bit tells full from empty
	logic [AW:0] base, used;
	logic        wr_en;

	// discard rewinds first, so a write in the same cycle lands after the committed words
	assign base  = i_op.discard ? cmt_ptr : wr_ptr;
	assign used  = wr_ptr - rd_ptr;
	assign wr_en = i_op.wr && !i_clear && ((base - rd_ptr) != (AW+1)'(DEPTH));

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr  <= '0;
			cmt_ptr <= '0;
			rd_ptr  <= '0;
		end
		else if (i_clear) begin
			wr_ptr  <= '0;
			cmt_ptr <= '0;
			rd_ptr  <= '0;
		end
		else begin
			wr_ptr <= base + (AW+1)'(wr_en);
			if (i_op.commit)
				cmt_ptr <= wr_ptr; // a same cycle write stays staged
			if (i_pop && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_rst) begin
		if (wr_en)
			mem[base[AW-1:0]] <= i_op.wr_word;
	end

	assign o_head  = mem[rd_ptr[AW-1:0]];
	assign o_empty = (cmt_ptr == rd_ptr); // committed words only
	assign o_free  = FW'(DEPTH) - FW'(used);

endmodule

`default_nettype wire

/* hw/spi_cmd_decoder.sv */
// ################################################
// MOSI command FSM: stages queueable commands, checks
// the word after CRC_OUT, handles ignore mode and
// serves REG_READ over the register read bus
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module spi_cmd_decoder (
	input  logic                                  clk_rst,
	input  logic                                  i_rst_n,
	input  logic                                  i_rx_valid,
	input  spi_cmd_pkg::spi_word_t                i_rx_word,
	input  logic [$clog2(`SPI_QUEUE_DEPTH+1)-1:0] i_queue_free,
	input  logic                                  i_reg_ready,
	input  logic [`SPI_WORD_W-1:0]                i_reg_rdata,
	input  logic                                  i_fifo_full,
	output spi_cmd_pkg::queue_op_t                o_queue_op,
	output logic                                  o_queue_clear,
	output logic                                  o_reg_rd,
	output logic [`SPI_REG_ADDR_W-1:0]            o_reg_addr,
	output logic [`SPI_WORD_W-1:0]                o_fifo_data,
	output logic                                  o_set_fifo_data,
	output logic                                  o_crc_error,
	output logic                                  o_set_command_ignored,
	output logic                                  o_command_incomplete,
	output logic                                  o_command_in_pending
);

	localparam int QW = $clog2(`SPI_QUEUE_DEPTH + 1);

	typedef enum logic [2:0] {
		idle, queue_words, wait_crc, read_register, read_next, ignore
	} state_t;

	state_t                    state, state_n;
	spi_cmd_pkg::cmd_len_t     word_cnt, word_cnt_n, len;
	logic [`SPI_REG_ADDR_W-1:0] addr_n;
	spi_cmd_pkg::queue_op_t    op_n;
	logic                      clear_n, set_fifo_n, crc_err_n, ignored_n, incomplete_n;
	logic                      have_data, have_data_n;
	logic                      held_q, held_n;
	spi_cmd_pkg::spi_word_t    held_word, held_word_n;
	spi_cmd_pkg::spi_word_t    word;
	logic                      word_sel, word_v, decode, is_reset_word;
	logic [QW-1:0]             free_eff;
	logic                      crc_check_q, crc_check_n, crc_restart, crc_ok;

	assign is_reset_word = i_rx_valid && (i_rx_word == `SPI_RESET_WORD);
	assign word_sel      = held_q && (state == read_next); // word caught during a read
	assign word          = word_sel ? held_word : i_rx_word;
	assign word_v        = i_rx_valid || word_sel;
	assign len           = spi_cmd_pkg::spi_cmd_length(word.opcode);
	assign free_eff      = i_queue_free - QW'(o_queue_op.wr); // write still in flight
	assign crc_restart   = crc_check_q || is_reset_word;

	spi_mosi_crc u_crc (
		.clk_rst     (clk_rst),
		.i_rst_n     (i_rst_n),
		.i_word_valid(i_rx_valid),
		.i_word      (i_rx_word),
		.i_restart   (crc_restart),
		.o_crc_ok    (crc_ok)
	);

	always_comb begin
		state_n      = state;
		word_cnt_n   = word_cnt;
		addr_n       = o_reg_addr;
		have_data_n  = have_data;
		held_n       = held_q;
		held_word_n  = held_word;
		clear_n      = 1'b0;
		set_fifo_n   = 1'b0;
		ignored_n    = 1'b0;
		incomplete_n = 1'b0;
		decode       = 1'b0;
		crc_check_n  = 1'b0;
		op_n         = '0;
		// residue is visible the cycle after the CRC word
		op_n.commit  = crc_check_q && crc_ok;
		op_n.discard = crc_check_q && !crc_ok;
		crc_err_n    = crc_check_q && !crc_ok;

		case (state)
			idle: decode = word_v;
			queue_words: begin
				if (word_v) begin
					op_n.wr      = 1'b1;
					op_n.wr_word = word;
					word_cnt_n   = word_cnt - 2'd1;
					if (word_cnt == 2'd1)
						state_n = idle;
				end
			end
			wait_crc: begin
				if (word_v) begin // this word is the CRC itself
					crc_check_n = 1'b1;
					state_n     = idle;
				end
			end
			read_register: begin
				if (i_reg_ready && o_reg_rd)
					have_data_n = 1'b1;
				if (have_data && !i_fifo_full) begin
					set_fifo_n  = 1'b1;
					have_data_n = 1'b0;
					state_n     = read_next;
				end
				if (i_rx_valid) begin
					held_n      = 1'b1;
					held_word_n = i_rx_word;
				end
			end
			read_next: begin
				if (word_v) begin
					held_n      = held_q && i_rx_valid;
					held_word_n = i_rx_word;
					if (word.opcode != spi_cmd_pkg::REG_READ) begin
						incomplete_n = 1'b1;
						decode       = 1'b1; // start the new command right away
					end
					else if (word.data == '0) begin
						state_n = idle;
					end
					else begin
						addr_n  = word.data[`SPI_REG_ADDR_W-1:0];
						state_n = read_register;
					end
				end
			end
			ignore: ignored_n = i_rx_valid && !is_reset_word;
			default: state_n = idle;
		endcase

		if (decode) begin
			state_n = idle;
			case (word.opcode)
				spi_cmd_pkg::IC_STATUS: ; // status goes out on MISO
				spi_cmd_pkg::CRC_OUT: state_n = wait_crc;
				spi_cmd_pkg::CLEAR_COMMAND_QUEUE: clear_n = 1'b1;
				spi_cmd_pkg::REG_READ: begin
					addr_n  = word.data[`SPI_REG_ADDR_W-1:0];
					state_n = read_register;
				end
				spi_cmd_pkg::SYNC, spi_cmd_pkg::REG_WRITE, spi_cmd_pkg::DSI_CRM: begin
					if (free_eff >= QW'(len)) begin
						op_n.wr      = 1'b1;
						op_n.wr_word = word;
						word_cnt_n   = len - 2'd1;
						state_n      = (len == 2'd1) ? idle : queue_words;
					end
					else begin
						ignored_n = 1'b1; // whole command would not fit
						state_n   = ignore;
					end
				end
				default: state_n = ignore;
			endcase
		end

		if (is_reset_word) begin
			state_n      = idle;
			word_cnt_n   = '0;
			have_data_n  = 1'b0;
			held_n       = 1'b0;
			ignored_n    = 1'b0;
			op_n.wr      = 1'b0;
			op_n.commit  = 1'b0;
			op_n.discard = 1'b1; // drop staged words
		end
	end

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state                 <= idle;
			word_cnt              <= '0;
			o_reg_addr            <= '0;
			o_queue_op            <= '0;
			o_queue_clear         <= 1'b0;
			o_reg_rd              <= 1'b0;
			o_set_fifo_data       <= 1'b0;
			o_crc_error           <= 1'b0;
			o_set_command_ignored <= 1'b0;
			o_command_incomplete  <= 1'b0;
			o_command_in_pending  <= 1'b0;
			have_data             <= 1'b0;
			held_q                <= 1'b0;
			crc_check_q           <= 1'b0;
		end
		else begin
			state                 <= state_n;
			word_cnt              <= word_cnt_n;
			o_reg_addr            <= addr_n;
			o_queue_op            <= op_n;
			o_queue_clear         <= clear_n;
			o_reg_rd              <= (state_n == read_register) && !have_data_n;
			o_set_fifo_data       <= set_fifo_n;
			o_crc_error           <= crc_err_n;
			o_set_command_ignored <= ignored_n;
			o_command_incomplete  <= incomplete_n;
			o_command_in_pending  <= !((state_n == idle) || (state_n == ignore));
			have_data             <= have_data_n;
			held_q                <= held_n;
			crc_check_q           <= crc_check_n;
		end
	end

	always_ff @(posedge clk_rst) begin
		held_word <= held_word_n;
		if ((state == read_register) && o_reg_rd && i_reg_ready)
			o_fifo_data <= i_reg_rdata; // held here until the response FIFO has room
	end

endmodule

`default_nettype wire

/* hw/spi_cmd_pkg.sv */
// ################################################
// shared types of the SPI command front end: words,
// opcodes, queue operations and command packets
// ################################################

`default_nettype none

`include "spi_cmd_consts.svh"

package spi_cmd_pkg;

	typedef enum logic [`SPI_OPC_W-1:0] {
		IC_STATUS           = 4'd0,
		CRC_OUT             = 4'd1,
		REG_READ            = 4'd2,
		REG_WRITE           = 4'd3,
		SYNC                = 4'd4,
		DSI_CRM             = 4'd5,
		CLEAR_COMMAND_QUEUE = 4'd6,
		RESET               = 4'd15
	} spi_opcode_e;

	typedef struct packed {
		spi_opcode_e              opcode;
		logic [`SPI_DATA_W-1:0]   data;
	} spi_word_t;

	// decoder to queue, one cycle strobes
	typedef struct packed {
		logic      wr;
		spi_word_t wr_word;
		logic      commit;
		logic      discard;
	} queue_op_t;

	typedef logic [1:0] cmd_len_t; // words per command, 0 if not queueable

	typedef struct packed {
		spi_opcode_e                         opcode;
		logic [`SPI_DATA_W-1:0]              data;
		spi_word_t [`SPI_CMD_MAX_ARGS-1:0]   args; // args[0] follows the first word
	} cmd_packet_t;

	function automatic cmd_len_t spi_cmd_length(input spi_opcode_e opcode);
		case (opcode)
			SYNC:      return 2'd1;
			REG_WRITE: return 2'd2;
			DSI_CRM:   return 2'd3;
			default:   return 2'd0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hw/spi_cmd_top.sv */
// ################################################
// command side of the SPI front end: decoder feeds
// the staged queue, dispatcher drains it
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module spi_cmd_top (
	input  logic                      clk_rst,
	input  logic                      i_rst_n,
	input  logic                      i_rx_valid,
	input  spi_cmd_pkg::spi_word_t    i_rx_word,
	input  logic                      i_reg_ready,
	input  logic [`SPI_WORD_W-1:0]    i_reg_rdata,
	input  logic                      i_fifo_full,
	output logic                      o_reg_rd,
	output logic [`SPI_REG_ADDR_W-1:0] o_reg_addr,
	output logic [`SPI_WORD_W-1:0]    o_fifo_data,
	output logic                      o_set_fifo_data,
	output spi_cmd_pkg::cmd_packet_t  o_cmd,
	output logic                      o_cmd_valid,
	output logic                      o_crc_error,
	output logic                      o_set_command_ignored,
	output logic                      o_command_incomplete,
	output logic                      o_command_in_pending
);

	spi_cmd_pkg::queue_op_t                  q_op;
	spi_cmd_pkg::spi_word_t                  q_head;
	logic                                    q_clear, q_empty, q_pop;
	logic [$clog2(`SPI_QUEUE_DEPTH+1)-1:0]   q_free;

	spi_cmd_decoder u_decoder (
		.clk_rst              (clk_rst),
		.i_rst_n              (i_rst_n),
		.i_rx_valid           (i_rx_valid),
		.i_rx_word            (i_rx_word),
		.i_queue_free         (q_free),
		.i_reg_ready          (i_reg_ready),
		.i_reg_rdata          (i_reg_rdata),
		.i_fifo_full          (i_fifo_full),
		.o_queue_op           (q_op),
		.o_queue_clear        (q_clear),
		.o_reg_rd             (o_reg_rd),
		.o_reg_addr           (o_reg_addr),
		.o_fifo_data          (o_fifo_data),
		.o_set_fifo_data      (o_set_fifo_data),
		.o_crc_error          (o_crc_error),
		.o_set_command_ignored(o_set_command_ignored),
		.o_command_incomplete (o_command_incomplete),
		.o_command_in_pending (o_command_in_pending)
	);

	cmd_queue u_queue (
		.clk_rst(clk_rst),
		.i_rst_n(i_rst_n),
		.i_op   (q_op),
		.i_clear(q_clear),
		.i_pop  (q_pop),
		.o_head (q_head),
		.o_empty(q_empty),
		.o_free (q_free)
	);

	cmd_dispatcher u_dispatcher (
		.clk_rst    (clk_rst),
		.i_rst_n    (i_rst_n),
		.i_head     (q_head),
		.i_empty    (q_empty),
		.o_pop      (q_pop),
		.o_cmd      (o_cmd),
		.o_cmd_valid(o_cmd_valid)
	);

endmodule

`default_nettype wire

/* hw/spi_mosi_crc.sv */
// ################################################
// running CRC-16 CCITT over whole MOSI words, MSB
// first; o_crc_ok flags a zero residue
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module spi_mosi_crc (
	input  logic                  clk_rst,
	input  logic                  i_rst_n,
	input  logic                  i_word_valid,
	input  spi_cmd_pkg::spi_word_t i_word,
	input  logic                  i_restart,
	output logic                  o_crc_ok
);

	logic [`SPI_WORD_W-1:0] crc_q;

	function automatic logic [`SPI_WORD_W-1:0] crc_fold(
		input logic [`SPI_WORD_W-1:0] crc,
		input logic [`SPI_WORD_W-1:0] word
	);
		logic [`SPI_WORD_W-1:0] c;
		logic fb;
		c = crc;
		for (int i = `SPI_WORD_W - 1; i >= 0; i--) begin
			fb = c[`SPI_WORD_W-1] ^ word[i];
			c = {c[`SPI_WORD_W-2:0], 1'b0};
			if (fb)
				c = c ^ `SPI_CRC_POLY;
		end
		return c;
	endfunction

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n)
			crc_q <= `SPI_CRC_INIT;
		else if (i_restart)
			crc_q <= `SPI_CRC_INIT; // wins over a word in the same cycle
		else if (i_word_valid)
			crc_q <= crc_fold(crc_q, i_word);
	end

	assign o_crc_ok = (crc_q == '0);

endmodule

`default_nettype wire

/* include/spi_cmd_consts.svh */
// ################################################
// widths, opcodes, CRC and queue constants for the
// SPI command front end, included by every RTL file
// ################################################

`ifndef SPI_CMD_CONSTS_SVH
`define SPI_CMD_CONSTS_SVH

// MOSI word layout
`define SPI_WORD_W       16
`define SPI_OPC_W        4
`define SPI_DATA_W       12

// register read bus
`define SPI_REG_ADDR_W   8

// word based CRC-16 CCITT
`define SPI_CRC_INIT     16'hFFFF
`define SPI_CRC_POLY     16'h1021

// command queue
`define SPI_QUEUE_DEPTH  8

// all ones, leaves ignore mode
`define SPI_RESET_WORD   16'hFFFF

// DSI_CRM carries the most argument words
`define SPI_CMD_MAX_ARGS 2

`endif

/* verif/tb_spi_cmd.sv */
// ################################################
// table driven testbench for the SPI command front
// end; rows give a word, its gap and expected pulses
// ################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_cmd_consts.svh"

module tb_spi_cmd;

	typedef struct packed {
		logic [15:0] word;
		logic [1:0]  kind; // 0 word, 1 good CRC, 2 bad CRC
		logic [4:0]  gap;
		logic        qd;   // word lands in the queue
		logic [4:0]  full; // cycles of i_fifo_full at row start
		logic [1:0]  n_err, n_ign, n_inc, n_fifo, n_pkt;
		logic        pend; // o_command_in_pending at row end
	} row_t;

	logic        clk_rst, i_rst_n, i_rx_valid, i_reg_ready, i_fifo_full;
	logic [15:0] rx_word, i_reg_rdata;
	logic        o_reg_rd, o_set_fifo_data, o_cmd_valid, o_crc_error;
	logic        o_set_command_ignored, o_command_incomplete, o_command_in_pending;
	logic [7:0]  o_reg_addr;
	logic [15:0] o_fifo_data;
	spi_cmd_pkg::cmd_packet_t o_cmd;

	row_t        rows[$];
	logic [15:0] staged[$], exp_words[$], fifo_exp[$];
	int          limit = 1000;
	int          cycles = 0;

	spi_cmd_top u_spi_cmd_top (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n),
		.i_rx_valid(i_rx_valid), .i_rx_word(rx_word),
		.i_reg_ready(i_reg_ready), .i_reg_rdata(i_reg_rdata), .i_fifo_full(i_fifo_full),
		.o_reg_rd(o_reg_rd), .o_reg_addr(o_reg_addr),
		.o_fifo_data(o_fifo_data), .o_set_fifo_data(o_set_fifo_data),
		.o_cmd(o_cmd), .o_cmd_valid(o_cmd_valid), .o_crc_error(o_crc_error),
		.o_set_command_ignored(o_set_command_ignored),
		.o_command_incomplete(o_command_incomplete),
		.o_command_in_pending(o_command_in_pending)
	);

	initial begin
		clk_rst = 1'b0;
		forever #20 clk_rst = ~clk_rst;
	end

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// reference CCITT step folding a word MSB first
	function automatic logic [15:0] fold_crc(input logic [15:0] crc, input logic [15:0] w);
		logic [15:0] c;
		c = crc;
		for (int i = 15; i >= 0; i--)
			c = (c[15] ^ w[i]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		return c;
	endfunction

	function automatic int cmd_words(input logic [3:0] opc);
		case (opc)
			4'h4: return 1; // SYNC
			4'h3: return 2; // REG_WRITE
			4'h5: return 3; // DSI_CRM
			default: return 1;
		endcase
	endfunction

	task automatic add_row(input logic [15:0] w, input int kind, input int gap, input bit qd,
		input int full, input int err, input int ign, input int inc, input int fifo,
		input int pkt, input bit pend);
		row_t r;
		r = '{w, kind[1:0], gap[4:0], qd, full[4:0], err[1:0], ign[1:0], inc[1:0],
			fifo[1:0], pkt[1:0], pend};
		rows.push_back(r);
	endtask

	task automatic take_word(output logic [15:0] w);
		if (exp_words.size() == 0) begin
			$display("Packet at %0t ns holds more words than were committed", $time);
			$display("Finished with errors");
			$fatal(1);
		end
		w = exp_words.pop_front();
	endtask

	task automatic check_packet();
		logic [15:0] w0, a0, a1;
		int n;
		take_word(w0);
		n  = cmd_words(w0[15:12]);
		a0 = '0;
		a1 = '0;
		if (n > 1)
			take_word(a0);
		if (n > 2)
			take_word(a1);
		compare_value("o_cmd", 64'(o_cmd), 64'({w0, a1, a0}));
	endtask

	// register responder answering addr ^ 0x5A00 after 1 to 4 cycles
	initial begin
		int delay;
		void'($urandom(20331));
		forever begin
			@(negedge clk_rst);
			if (o_reg_rd && i_rst_n) begin
				delay = $urandom_range(1, 4);
				repeat (delay) @(negedge clk_rst);
				i_reg_ready = 1'b1;
				i_reg_rdata = {8'h00, o_reg_addr} ^ 16'h5A00;
				@(negedge clk_rst);
				i_reg_ready = 1'b0;
			end
		end
	end

	always @(posedge clk_rst) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles, run did not finish", cycles);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	initial begin
		row_t        r;
		logic [15:0] w, crc_acc;
		int          n_err, n_ign, n_inc, n_fifo, n_pkt;

		i_rst_n     = 1'b0;
		i_rx_valid  = 1'b0;
		rx_word     = '0;
		i_reg_ready = 1'b0;
		i_reg_rdata = '0;
		i_fifo_full = 1'b0;
		crc_acc     = `SPI_CRC_INIT;

		// three commands under one commit
		add_row(16'h4001, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h3012, 0, 3, 1, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0345, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h5001, 0, 3, 1, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0123, 0, 3, 1, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0456, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 16, 0, 0, 0, 0, 0, 0, 3, 0);
		// wrong CRC drops the command
		add_row(16'h4002, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 2, 8, 0, 0, 1, 0, 0, 0, 0, 0);
		add_row(16'h4003, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 10, 0, 0, 0, 0, 0, 0, 1, 0);
		// unknown opcode enters ignore mode until RESET
		add_row(16'h9000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h4004, 0, 3, 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(16'h3001, 0, 3, 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(16'hFFFF, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h4005, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 10, 0, 0, 0, 0, 0, 0, 1, 0);
		// chained register reads with the second held by a full FIFO
		add_row(16'h2011, 0, 12, 0, 0, 0, 0, 0, 1, 0, 1);
		add_row(16'h2022, 0, 24, 0, 12, 0, 0, 0, 1, 0, 1);
		add_row(16'h2000, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0);
		// read cut short by SYNC
		add_row(16'h2033, 0, 12, 0, 0, 0, 0, 0, 1, 0, 1);
		add_row(16'h4006, 0, 4, 1, 0, 0, 0, 1, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 10, 0, 0, 0, 0, 0, 0, 1, 0);
		// clear and then overflow of the queue
		add_row(16'h4007, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h3001, 0, 3, 1, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0002, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h6000, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 8, 0, 0, 0, 0, 0, 0, 0, 0);
		for (int i = 0; i < 8; i++)
			add_row(16'h4008 + 16'(i), 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h4010, 0, 3, 0, 0, 0, 1, 0, 0, 0, 0); // ninth word does not fit
		add_row(16'hFFFF, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h4011, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(16'h1000, 0, 3, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(16'h0000, 1, 10, 0, 0, 0, 0, 0, 0, 1, 0);
		limit = 40 * rows.size() + 200;

		repeat (10) @(negedge clk_rst);
		i_rst_n = 1'b1;
		@(negedge clk_rst);

		foreach (rows[k]) begin
			r = rows[k];
			w = (r.kind == 2'd1) ? crc_acc : (r.kind == 2'd2) ? (crc_acc ^ 16'h0001) : r.word;
			if (r.kind != 2'd0) begin
				if (r.kind == 2'd1)
					foreach (staged[j])
						exp_words.push_back(staged[j]);
				staged.delete();
				crc_acc = `SPI_CRC_INIT;
			end
			else if (w == `SPI_RESET_WORD) begin
				staged.delete();
				crc_acc = `SPI_CRC_INIT;
			end
			else begin
				crc_acc = fold_crc(crc_acc, w);
				if (r.qd)
					staged.push_back(w);
				else if (w[15:12] == 4'h6)
					staged.delete();
				else if (w[15:12] == 4'h2 && w[11:0] != '0)
					fifo_exp.push_back({8'h00, w[7:0]} ^ 16'h5A00);
			end

			i_rx_valid  = 1'b1;
			rx_word     = w;
			i_fifo_full = (r.full != '0);
			n_err  = 0;
			n_ign  = 0;
			n_inc  = 0;
			n_fifo = 0;
			n_pkt  = 0;
			for (int g = 0; g < r.gap; g++) begin
				@(negedge clk_rst);
				i_rx_valid = 1'b0;
				n_err += int'(o_crc_error);
				n_ign += int'(o_set_command_ignored);
				n_inc += int'(o_command_incomplete);
				if (o_set_fifo_data) begin
					compare_value("o_set_fifo_data while full", 64'(i_fifo_full), 64'd0);
					compare_value("o_set_fifo_data count", 64'(fifo_exp.size() > 0), 64'd1);
					compare_value("o_fifo_data", 64'(o_fifo_data), 64'(fifo_exp.pop_front()));
					n_fifo++;
				end
				if (o_cmd_valid) begin
					check_packet();
					n_pkt++;
				end
				i_fifo_full = (g + 1 < r.full);
			end
			compare_value("o_crc_error pulses", 64'(n_err), 64'(r.n_err));
			compare_value("o_set_command_ignored pulses", 64'(n_ign), 64'(r.n_ign));
			compare_value("o_command_incomplete pulses", 64'(n_inc), 64'(r.n_inc));
			compare_value("o_set_fifo_data pulses", 64'(n_fifo), 64'(r.n_fifo));
			compare_value("o_cmd_valid pulses", 64'(n_pkt), 64'(r.n_pkt));
			compare_value("o_command_in_pending", 64'(o_command_in_pending), 64'(r.pend));
			compare_value("o_reg_rd at row end", 64'(o_reg_rd), 64'd0);
		end

		repeat (20) begin
			@(negedge clk_rst);
			compare_value("late o_cmd_valid", 64'(o_cmd_valid), 64'd0);
		end
		compare_value("committed words left", 64'(exp_words.size()), 64'd0);
		compare_value("register reads left", 64'(fifo_exp.size()), 64'd0);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
